// ==== csr_file.sv ====
module csr_file (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      wen_in,
    input  csr_regs_pkg::csr_addr_t   addr_in,
    input  csr_regs_pkg::csr_word_t   wdata_in,
    input  logic                      d_idle,
    input  csr_trap_pkg::trap_event_t ev,
    input  csr_trap_pkg::hw_irq_t     hardware_interrupt,
    output csr_regs_pkg::csr_word_t   rdata,
    output csr_regs_pkg::csr_word_t   crmd,
    output csr_regs_pkg::csr_word_t   estat,
    output csr_regs_pkg::csr_word_t   era_out,
    output csr_regs_pkg::csr_word_t   eentry,
    output logic                      cpu_interrupt,
    output logic                      idle_over,
    output logic                      wen_csr
);
    import csr_regs_pkg::*;

    csr_wr_t   wr;
    logic      ti_pending;
    csr_word_t prmd;
    csr_word_t ecfg;
    csr_word_t badv;
    csr_word_t tcfg;
    csr_word_t tval;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;

    csr_write_stage u_write_stage (
        .clk      (clk),
        .aresetn  (aresetn),
        .wen_in   (wen_in),
        .addr_in  (addr_in),
        .wdata_in (wdata_in),
        .d_idle   (d_idle),
        .wen_csr  (wen_csr),
        .wr       (wr)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk                (clk),
        .aresetn            (aresetn),
        .wr                 (wr),
        .ev                 (ev),
        .hardware_interrupt (hardware_interrupt),
        .ti_pending         (ti_pending),
        .crmd               (crmd),
        .prmd               (prmd),
        .ecfg               (ecfg),
        .estat              (estat),
        .era                (era_out),
        .badv               (badv),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over)
    );

    csr_timer u_timer (
        .clk        (clk),
        .aresetn    (aresetn),
        .wr         (wr),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_pending (ti_pending)
    );

    csr_scratch u_scratch (
        .clk     (clk),
        .aresetn (aresetn),
        .wr      (wr),
        .eentry  (eentry),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3)
    );

    // TICLR and unknown numbers read zero
    always_comb begin
        case (addr_in)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era_out;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry;
            CSR_SAVE0:  rdata = save0;
            CSR_SAVE1:  rdata = save1;
            CSR_SAVE2:  rdata = save2;
            CSR_SAVE3:  rdata = save3;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            default:    rdata = '0;
        endcase
    end

endmodule

// ==== csr_regs_pkg.sv ====
package csr_regs_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_addr_t;

    // Register numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // CRMD fields
    // PRMD keeps PPLV and PIE at the same places
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    // DA=1, DATF=1, DATM=1
    localparam csr_word_t CRMD_RESET = 32'h0000_00a8;

    // TCFG fields
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;

    // EENTRY bits below this read as zero
    localparam int EENTRY_VA_LSB = 6;

    // Committed write bus
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_word_t data;
    } csr_wr_t;

endpackage

// ==== csr_scratch.sv ====
module csr_scratch (
    input  logic                    clk,
    input  logic                    aresetn,
    input  csr_regs_pkg::csr_wr_t   wr,
    output csr_regs_pkg::csr_word_t eentry,
    output csr_regs_pkg::csr_word_t save0,
    output csr_regs_pkg::csr_word_t save1,
    output csr_regs_pkg::csr_word_t save2,
    output csr_regs_pkg::csr_word_t save3
);
    import csr_regs_pkg::*;

    logic [31:EENTRY_VA_LSB] va_q;
    csr_word_t               save_q [4];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            va_q <= '0;
        end else if (wr.en && wr.addr == CSR_EENTRY) begin
            va_q <= wr.data[31:EENTRY_VA_LSB];
        end
    end

    // SAVE0..SAVE3 sit on consecutive numbers
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr.en && wr.addr == csr_addr_t'(CSR_SAVE0 + i)) begin
                    save_q[i] <= wr.data;
                end
            end
        end
    end

    assign eentry = {va_q, {EENTRY_VA_LSB{1'b0}}};
    assign save0  = save_q[0];
    assign save1  = save_q[1];
    assign save2  = save_q[2];
    assign save3  = save_q[3];

endmodule

// ==== csr_timer.sv ====
module csr_timer (
    input  logic                    clk,
    input  logic                    aresetn,
    input  csr_regs_pkg::csr_wr_t   wr,
    output csr_regs_pkg::csr_word_t tcfg,
    output csr_regs_pkg::csr_word_t tval,
    output logic                    ti_pending
);
    import csr_regs_pkg::*;

    logic                          en_q;
    logic                          periodic_q;
    logic [31:TCFG_INITVAL_LO]     initval_q;
    logic                          reload_q;
    logic                          time_out_q;
    csr_word_t                     tval_q;
    logic                          wr_tcfg;
    logic                          wr_ticlr;

    assign wr_tcfg  = wr.en && (wr.addr == CSR_TCFG);
    assign wr_ticlr = wr.en && (wr.addr == CSR_TICLR);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
            reload_q   <= 1'b0;
        end else begin
            reload_q <= wr_tcfg;
            if (wr_tcfg) begin
                en_q       <= wr.data[TCFG_EN];
                periodic_q <= wr.data[TCFG_PERIODIC];
                initval_q  <= wr.data[31:TCFG_INITVAL_LO];
            end
        end
    end

    // Reload adds one so an INITVAL of zero still expires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_q     <= '0;
            time_out_q <= 1'b0;
        end else if (reload_q || (tval_q == '0 && en_q && periodic_q)) begin
            tval_q     <= {initval_q, 2'b01};
            time_out_q <= 1'b0;
        end else if (tval_q == '0) begin
            time_out_q <= 1'b0;
        end else if (en_q) begin
            tval_q     <= tval_q - 1'b1;
            time_out_q <= (tval_q == 32'd1);
        end
    end

    // Clear wins over a coincident expiry
    always_ff @(posedge clk) begin
        if (!aresetn || wr_ticlr) begin
            ti_pending <= 1'b0;
        end else if (time_out_q) begin
            ti_pending <= 1'b1;
        end
    end

    assign tcfg = {initval_q, periodic_q, en_q};
    assign tval = tval_q;

endmodule

// ==== csr_trap_ctrl.sv ====
module csr_trap_ctrl (
    input  logic                       clk,
    input  logic                       aresetn,
    input  csr_regs_pkg::csr_wr_t      wr,
    input  csr_trap_pkg::trap_event_t  ev,
    input  csr_trap_pkg::hw_irq_t      hardware_interrupt,
    input  logic                       ti_pending,
    output csr_regs_pkg::csr_word_t    crmd,
    output csr_regs_pkg::csr_word_t    prmd,
    output csr_regs_pkg::csr_word_t    ecfg,
    output csr_regs_pkg::csr_word_t    estat,
    output csr_regs_pkg::csr_word_t    era,
    output csr_regs_pkg::csr_word_t    badv,
    output logic                       cpu_interrupt,
    output logic                       idle_over
);
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;

    csr_word_t                       crmd_q;
    csr_word_t                       prmd_q;
    logic [INT_BITS-1:0]             lie_q;
    logic [ESTAT_SOFT_HI:ESTAT_SOFT_LO] soft_q;
    ecode_t                          ecode_q;
    logic                            subcode_q;
    csr_word_t                       era_q;
    csr_word_t                       badv_q;
    ecode_t                          ev_ecode;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ecfg;
    logic wr_estat;
    logic wr_era;
    logic wr_badv;

    assign wr_crmd  = wr.en && (wr.addr == CSR_CRMD);
    assign wr_prmd  = wr.en && (wr.addr == CSR_PRMD);
    assign wr_ecfg  = wr.en && (wr.addr == CSR_ECFG);
    assign wr_estat = wr.en && (wr.addr == CSR_ESTAT);
    assign wr_era   = wr.en && (wr.addr == CSR_ERA);
    assign wr_badv  = wr.en && (wr.addr == CSR_BADV);

    assign ev_ecode = ev.expcode[$bits(ecode_t)-1:0];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_q <= CRMD_RESET;
        end else if (ev.ertn) begin
            crmd_q[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd_q[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_q[CRMD_IE]                 <= prmd_q[CRMD_IE];
        end else if (ev.exception) begin
            crmd_q[CRMD_PLV_HI:CRMD_PLV_LO] <= '0;
            crmd_q[CRMD_IE]                 <= 1'b0;
        end else if (wr_crmd) begin
            crmd_q[CRMD_PLV_HI:CRMD_PLV_LO]   <= wr.data[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_q[CRMD_IE]                   <= wr.data[CRMD_IE];
            crmd_q[CRMD_DATF_HI:CRMD_DATF_LO] <= wr.data[CRMD_DATF_HI:CRMD_DATF_LO];
            crmd_q[CRMD_DATM_HI:CRMD_DATM_LO] <= wr.data[CRMD_DATM_HI:CRMD_DATM_LO];
            // Only direct or paged mode, never both or neither
            if (wr.data[CRMD_PG] ^ wr.data[CRMD_DA]) begin
                crmd_q[CRMD_PG] <= wr.data[CRMD_PG];
                crmd_q[CRMD_DA] <= wr.data[CRMD_DA];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_q <= '0;
        end else if (ev.exception) begin
            prmd_q[CRMD_IE:CRMD_PLV_LO] <= crmd_q[CRMD_IE:CRMD_PLV_LO];
        end else if (wr_prmd) begin
            prmd_q[CRMD_IE:CRMD_PLV_LO] <= wr.data[CRMD_IE:CRMD_PLV_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q <= '0;
        end else if (wr_ecfg) begin
            lie_q <= wr.data[INT_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            soft_q    <= '0;
            ecode_q   <= '0;
            subcode_q <= 1'b0;
        end else if (ev.exception || ev.wen_expcode) begin
            ecode_q   <= ev_ecode;
            subcode_q <= (ev_ecode == '0) ? 1'b0 : ev.expcode[$bits(ecode_t)];
        end else if (wr_estat) begin
            soft_q <= wr.data[ESTAT_SOFT_HI:ESTAT_SOFT_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q <= '0;
        end else if (ev.wen_era) begin
            era_q <= ev.era;
        end else if (wr_era) begin
            era_q <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            badv_q <= '0;
        end else if (ev.wen_badv) begin
            badv_q <= ev.badv;
        end else if (wr_badv) begin
            badv_q <= wr.data;
        end
    end

    // Hardware lines are mirrored, not latched
    always_comb begin
        estat                                 = '0;
        estat[ESTAT_SOFT_HI:ESTAT_SOFT_LO]    = soft_q;
        estat[ESTAT_HARD_HI:ESTAT_HARD_LO]    = hardware_interrupt;
        estat[ESTAT_TI]                       = ti_pending;
        estat[ESTAT_IPI]                      = 1'b0;
        estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]  = ecode_q;
        estat[ESTAT_SUBCODE]                  = subcode_q;
    end

    assign crmd = crmd_q;
    assign prmd = prmd_q;
    assign ecfg = csr_word_t'(lie_q);
    assign era  = era_q;
    assign badv = badv_q;

    assign cpu_interrupt = crmd_q[CRMD_IE] && |(lie_q & estat[INT_BITS-1:0]);
    // Any pending source ends idle, enabled or not
    assign idle_over     = |estat[INT_BITS-1:0];

endmodule

// ==== csr_trap_pkg.sv ====
package csr_trap_pkg;

    // Bit 6 is the subcode, bits 5:0 the exception code
    typedef logic [6:0] expcode_t;
    typedef logic [5:0] ecode_t;
    typedef logic [7:0] hw_irq_t;

    // Interrupt status and local enable width
    localparam int INT_BITS = 13;

    // ESTAT layout
    localparam int ESTAT_SOFT_LO  = 0;
    localparam int ESTAT_SOFT_HI  = 1;
    localparam int ESTAT_HARD_LO  = 2;
    localparam int ESTAT_HARD_HI  = 9;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_IPI      = 12;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_SUBCODE  = 22;

    // Strobes from the pipeline at exception entry and return
    typedef struct packed {
        logic                  exception;
        logic                  ertn;
        expcode_t              expcode;
        logic                  wen_expcode;
        csr_regs_pkg::csr_word_t era;
        logic                  wen_era;
        csr_regs_pkg::csr_word_t badv;
        logic                  wen_badv;
    } trap_event_t;

endpackage

// ==== csr_write_stage.sv ====
module csr_write_stage (
    input  logic                    clk,
    input  logic                    aresetn,
    input  logic                    wen_in,
    input  csr_regs_pkg::csr_addr_t addr_in,
    input  csr_regs_pkg::csr_word_t wdata_in,
    input  logic                    d_idle,
    output logic                    wen_csr,
    output csr_regs_pkg::csr_wr_t   wr
);
    import csr_regs_pkg::*;

    typedef enum logic [1:0] {
        WR_EMPTY,
        WR_HELD,
        WR_COMMIT
    } wr_state_e;

    wr_state_e state_q;
    wr_state_e state_d;
    csr_addr_t addr_q;
    csr_word_t data_q;

    // Latest request wins while nothing has been accepted yet
    always_ff @(posedge clk) begin
        if (wen_in) begin
            addr_q <= addr_in;
            data_q <= wdata_in;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_EMPTY:  if (wen_in) state_d = WR_HELD;
            WR_HELD:   if (d_idle) state_d = WR_COMMIT;
            WR_COMMIT: state_d = wen_in ? WR_HELD : WR_EMPTY;
            default:   state_d = WR_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state_q <= WR_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Accept when the data side goes idle
    assign wen_csr = (state_q == WR_HELD) && d_idle;

    assign wr.en   = (state_q == WR_COMMIT);
    assign wr.addr = addr_q;
    assign wr.data = data_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_csr_file -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_csr_file > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== tb.f ====
csr_regs_pkg.sv
csr_trap_pkg.sv
csr_write_stage.sv
csr_trap_ctrl.sv
csr_timer.sv
csr_scratch.sv
csr_file.sv
tb_csr_file.sv

// ==== tb_csr_file.sv ====
module tb_csr_file;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_regs_pkg::*;
    import csr_trap_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        aresetn;
    logic        wen_in;
    csr_addr_t   addr_in;
    csr_word_t   wdata_in;
    logic        d_idle;
    trap_event_t ev;
    hw_irq_t     hardware_interrupt;
    csr_word_t   rdata;
    csr_word_t   crmd;
    csr_word_t   estat;
    csr_word_t   era_out;
    csr_word_t   eentry;
    logic        cpu_interrupt;
    logic        idle_over;
    logic        wen_csr;
    int          error_count;
    int          timeout_count;

    csr_file dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    // Expected CRMD word built from its fields
    function automatic csr_word_t crmd_word(logic [1:0] plv, logic ie, logic da, logic pg,
                                            logic [1:0] datf, logic [1:0] datm);
        csr_word_t w;
        w = '0;
        w[CRMD_PLV_HI:CRMD_PLV_LO]   = plv;
        w[CRMD_IE]                   = ie;
        w[CRMD_DA]                   = da;
        w[CRMD_PG]                   = pg;
        w[CRMD_DATF_HI:CRMD_DATF_LO] = datf;
        w[CRMD_DATM_HI:CRMD_DATM_LO] = datm;
        return w;
    endfunction

    task automatic read_check(input string name, input csr_addr_t addr, input csr_word_t exp);
        @(posedge clk);
        #2 addr_in = addr;
        @(negedge clk);
        check_word(name, rdata, exp);
    endtask

    task automatic expect_irq(input logic exp_cpu, input logic exp_idle);
        @(negedge clk);
        check_bit("cpu_interrupt", cpu_interrupt, exp_cpu);
        check_bit("idle_over", idle_over, exp_idle);
    endtask

    task automatic request_write(input csr_addr_t addr, input csr_word_t data, input logic idle);
        @(posedge clk);
        #2;
        wen_in   = 1'b1;
        addr_in  = addr;
        wdata_in = data;
        d_idle   = idle;
        @(posedge clk);
        #2 wen_in = 1'b0;
    endtask

    // Accept pulse, then the commit cycle, then the register edge
    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (wen_csr !== 1'b1 && n < WAIT_LIMIT);
        if (wen_csr !== 1'b1) begin
            $display("Timeout: the DUT never accepted the held write at %0t", $time);
            timeout_count++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_word_t data);
        request_write(addr, data, 1'b1);
        wait_accept();
    endtask

    task automatic pulse_event(input trap_event_t e);
        @(posedge clk);
        #2 ev = e;
        @(posedge clk);
        #2 ev = '0;
    endtask

    task automatic wait_timer_irq();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (estat[ESTAT_TI] !== 1'b1 && n < WAIT_LIMIT);
        if (estat[ESTAT_TI] !== 1'b1) begin
            $display("Timeout: the timer interrupt bit in ESTAT never set at %0t", $time);
            timeout_count++;
        end
    endtask

    task automatic reset_values();
        csr_addr_t zero_regs [13] = '{CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                      CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                      CSR_TCFG, CSR_TVAL, CSR_TICLR};
        read_check("CRMD", CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        check_word("crmd", crmd, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        foreach (zero_regs[i]) begin
            read_check($sformatf("rdata at 0x%0h", zero_regs[i]), zero_regs[i], '0);
        end
        check_word("eentry", eentry, '0);
        check_bit("wen_csr", wen_csr, 1'b0);
        expect_irq(1'b0, 1'b0);
    endtask

    task automatic staged_writes();
        csr_word_t data [4];
        csr_word_t va;
        for (int i = 0; i < 4; i++) begin
            data[i] = $urandom();
        end
        va = $urandom();
        // Data side busy, so the write must wait
        request_write(CSR_SAVE0, data[0], 1'b0);
        repeat (6) begin
            @(negedge clk);
            check_bit("wen_csr", wen_csr, 1'b0);
        end
        read_check("SAVE0", CSR_SAVE0, '0);
        @(posedge clk);
        #2 d_idle = 1'b1;
        wait_accept();
        for (int i = 1; i < 4; i++) begin
            write_reg(csr_addr_t'(CSR_SAVE0 + i), data[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_check($sformatf("SAVE%0d", i), csr_addr_t'(CSR_SAVE0 + i), data[i]);
        end
        write_reg(CSR_EENTRY, va);
        read_check("EENTRY", CSR_EENTRY, va & ~32'h3f);
        check_word("eentry", eentry, va & ~32'h3f);
        // PG and DA both set keeps the old mode
        write_reg(CSR_CRMD, crmd_word(2'd2, 1'b0, 1'b1, 1'b1, 2'd2, 2'd3));
        read_check("CRMD", CSR_CRMD, crmd_word(2'd2, 1'b0, 1'b1, 1'b0, 2'd2, 2'd3));
        write_reg(CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b0, 1'b1, 2'd1, 2'd1));
        read_check("CRMD", CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b0, 1'b1, 2'd1, 2'd1));
        write_reg(CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        read_check("CRMD", CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
    endtask

    task automatic exception_return();
        trap_event_t e;
        csr_word_t   era_val;
        csr_word_t   badv_val;
        era_val  = $urandom();
        badv_val = $urandom();
        write_reg(CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b1, 1'b0, 2'd1, 2'd1));
        e             = '0;
        e.exception   = 1'b1;
        e.expcode     = {1'b1, 6'h0d};
        e.wen_expcode = 1'b1;
        e.era         = era_val;
        e.wen_era     = 1'b1;
        e.badv        = badv_val;
        e.wen_badv    = 1'b1;
        pulse_event(e);
        read_check("CRMD", CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        check_word("crmd", crmd, crmd_word(2'd0, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        // PPLV 3 and PIE 1
        read_check("PRMD", CSR_PRMD, 32'h7);
        read_check("ESTAT", CSR_ESTAT, (32'h0d << ESTAT_ECODE_LO) | (32'h1 << ESTAT_SUBCODE));
        check_word("estat", estat, (32'h0d << ESTAT_ECODE_LO) | (32'h1 << ESTAT_SUBCODE));
        check_word("era_out", era_out, era_val);
        read_check("ERA", CSR_ERA, era_val);
        read_check("BADV", CSR_BADV, badv_val);
        // Zero ecode drops the subcode
        e             = '0;
        e.expcode     = {1'b1, 6'h00};
        e.wen_expcode = 1'b1;
        pulse_event(e);
        read_check("ESTAT", CSR_ESTAT, '0);
        e      = '0;
        e.ertn = 1'b1;
        pulse_event(e);
        read_check("CRMD", CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b1, 1'b0, 2'd1, 2'd1));
    endtask

    task automatic interrupt_enables();
        write_reg(CSR_CRMD, crmd_word(2'd3, 1'b0, 1'b1, 1'b0, 2'd1, 2'd1));
        @(posedge clk);
        #2 hardware_interrupt = 8'h04;
        expect_irq(1'b0, 1'b1);
        // Line 2 shows up in ESTAT bit 4
        write_reg(CSR_ECFG, 32'h1 << (ESTAT_HARD_LO + 2));
        expect_irq(1'b0, 1'b1);
        write_reg(CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b1, 1'b0, 2'd1, 2'd1));
        expect_irq(1'b1, 1'b1);
        write_reg(CSR_ECFG, '0);
        expect_irq(1'b0, 1'b1);
        @(posedge clk);
        #2 hardware_interrupt = '0;
        expect_irq(1'b0, 1'b0);
        write_reg(CSR_ESTAT, 32'h2);
        expect_irq(1'b0, 1'b1);
        write_reg(CSR_ECFG, 32'h2);
        expect_irq(1'b1, 1'b1);
        read_check("ESTAT", CSR_ESTAT, 32'h2);
        write_reg(CSR_ESTAT, '0);
        write_reg(CSR_ECFG, '0);
        expect_irq(1'b0, 1'b0);
    endtask

    task automatic timer_expiry();
        write_reg(CSR_ECFG, 32'h1 << ESTAT_TI);
        // One-shot with INITVAL 3
        write_reg(CSR_TCFG, (32'd3 << TCFG_INITVAL_LO) | 32'h1);
        read_check("TCFG", CSR_TCFG, (32'd3 << TCFG_INITVAL_LO) | 32'h1);
        wait_timer_irq();
        check_bit("cpu_interrupt", cpu_interrupt, 1'b1);
        write_reg(CSR_TICLR, 32'h1);
        @(negedge clk);
        check_bit("estat[11]", estat[ESTAT_TI], 1'b0);
        repeat (40) @(negedge clk);
        check_bit("estat[11]", estat[ESTAT_TI], 1'b0);
        check_bit("cpu_interrupt", cpu_interrupt, 1'b0);
        read_check("TVAL", CSR_TVAL, '0);
        write_reg(CSR_TCFG, (32'd3 << TCFG_INITVAL_LO) | 32'h3);
        wait_timer_irq();
        write_reg(CSR_TICLR, 32'h1);
        @(negedge clk);
        check_bit("estat[11]", estat[ESTAT_TI], 1'b0);
        wait_timer_irq();
        write_reg(CSR_TCFG, '0);
        write_reg(CSR_TICLR, 32'h1);
    endtask

    initial begin
        void'($urandom(32'h78f5e6d4));
        error_count        = 0;
        timeout_count      = 0;
        aresetn            = 1'b0;
        wen_in             = 1'b0;
        addr_in            = '0;
        wdata_in           = '0;
        d_idle             = 1'b0;
        ev                 = '0;
        hardware_interrupt = '0;
        repeat (8) @(posedge clk);
        #2 aresetn = 1'b1;
        reset_values();
        staged_writes();
        exception_return();
        interrupt_enables();
        timer_expiry();
        $display("Value errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
